//--- dv/clockGen.sv
// Testbench clock and reset
// Free-running clock and an active-low reset held for a fixed number of cycles

`timescale 1ns/100ps

module clockGen #(
    parameter int halfPeriod  = 2,
    parameter int resetCycles = 10
) (
    output logic CLK,
    output logic rstN
);

    initial CLK = 1'b0;

    always #(halfPeriod) CLK = ~CLK;

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge CLK);
        rstN <= 1'b1;  // Release on a rising edge
    end

endmodule

//--- dv/rvCoreTb.sv
// Testbench for the RV32I core
// Builds a random program, predicts its register writes with an ISA-level
// interpreter and checks the writeback port against them in order

`timescale 1ns/100ps

module rvCoreTb;
    import rvIsaPkg::*;

    localparam word_t resetPc   = 32'h00400000;
    localparam int    progLen   = 96;
    localparam int    bodyStart = 31;            // After the register init block
    localparam int    haltIdx   = progLen - 1;
    localparam word_t haltPc    = resetPc + word_t'(4 * haltIdx);
    localparam word_t nopWord   = 32'h00000013;  // ADDI x0, x0, 0
    localparam int    runLimit  = 2000;          // Cycles

    typedef enum logic [3:0] {
        kAdd, kSub, kAnd, kOr, kXor, kSlt, kAddi, kLui, kAuipc, kBeq, kBne, kJal
    } kind_e;

    typedef struct packed {
        kind_e   kind;
        regIdx_t rd;
        regIdx_t rs1;
        regIdx_t rs2;
        word_t   imm;   // Extended value or jump byte offset
    } instrInfo_t;

    typedef struct packed {
        word_t   pc;
        regIdx_t rd;
        word_t   data;
    } commit_t;

    logic       CLK;
    logic       rstN;
    word_t      pc;
    word_t      instr;
    logic       wbValid;
    regIdx_t    wbRd;
    word_t      wbData;
    word_t      wbPc;
    word_t      prog [progLen];
    instrInfo_t info [progLen];
    commit_t    expQ [$];
    int         seenCount = 0;
    logic       inProg;
    logic [6:0] progIdx;

    clockGen #(.resetCycles(10)) clocks (.CLK(CLK), .rstN(rstN));

    rvCore #(.resetPc(resetPc)) dut (
        .CLK     (CLK),
        .rstN    (rstN),
        .instr   (instr),
        .pc      (pc),
        .wbValid (wbValid),
        .wbRd    (wbRd),
        .wbData  (wbData),
        .wbPc    (wbPc)
    );

    // Same-cycle instruction port lookup
    assign inProg  = (pc >= resetPc) && (pc < resetPc + word_t'(4 * progLen));
    assign progIdx = 7'((pc - resetPc) >> 2);
    assign instr   = inProg ? prog[progIdx] : nopWord;

    // ==================================================
    // Program generation
    // ==================================================
    function automatic word_t encode(instrInfo_t op);
        case (op.kind)
            kAdd:    return {7'h00, op.rs2, op.rs1, f3AddSub, op.rd, opReg};
            kSub:    return {7'h20, op.rs2, op.rs1, f3AddSub, op.rd, opReg};
            kAnd:    return {7'h00, op.rs2, op.rs1, f3And, op.rd, opReg};
            kOr:     return {7'h00, op.rs2, op.rs1, f3Or, op.rd, opReg};
            kXor:    return {7'h00, op.rs2, op.rs1, f3Xor, op.rd, opReg};
            kSlt:    return {7'h00, op.rs2, op.rs1, f3Slt, op.rd, opReg};
            kAddi:   return {op.imm[11:0], op.rs1, f3AddSub, op.rd, opImm};
            kLui:    return {op.imm[31:12], op.rd, opLui};
            kAuipc:  return {op.imm[31:12], op.rd, opAuipc};
            kBeq:    return {op.imm[12], op.imm[10:5], op.rs2, op.rs1, f3Beq,
                             op.imm[4:1], op.imm[11], opBranch};
            kBne:    return {op.imm[12], op.imm[10:5], op.rs2, op.rs1, f3Bne,
                             op.imm[4:1], op.imm[11], opBranch};
            default: return {op.imm[20], op.imm[10:1], op.imm[11], op.imm[19:12], op.rd, opJal};
        endcase
    endfunction

    function automatic void buildProgram();
        instrInfo_t op;
        word_t      raw;
        int         hopMax;
        for (int i = 0; i < haltIdx; i++) begin
            raw     = $urandom;
            hopMax  = (haltIdx - i < 8) ? haltIdx - i : 8;  // Forward only and never past halt
            op.kind = kind_e'($urandom_range(11, 0));
            op.rd   = regIdx_t'($urandom_range(7, 0));      // Small set for dependencies
            op.rs1  = regIdx_t'($urandom_range(7, 0));
            op.rs2  = regIdx_t'($urandom_range(7, 0));
            if (i < bodyStart) begin
                op.kind = kAddi;  // Known value in every register
                op.rd   = regIdx_t'(i + 1);
                op.rs1  = '0;
            end
            if ((op.kind == kBeq || op.kind == kBne) && raw[31]) begin
                op.rs2 = op.rs1;
            end
            case (op.kind)
                kLui, kAuipc:     op.imm = {raw[31:12], 12'b0};
                kBeq, kBne, kJal: op.imm = word_t'(4 * $urandom_range(hopMax, 1));
                default:          op.imm = {{20{raw[11]}}, raw[11:0]};
            endcase
            info[7'(i)] = op;
            prog[7'(i)] = encode(op);
        end
        // Halt loop
        op.kind = kJal;
        op.rd   = '0;
        op.rs1  = '0;
        op.rs2  = '0;
        op.imm  = '0;
        info[7'(haltIdx)] = op;
        prog[7'(haltIdx)] = encode(op);
    endfunction

    // ==================================================
    // ISA reference
    // ==================================================
    function automatic void refRun();
        word_t      regs [32];
        word_t      curPc;
        word_t      nextPc;
        word_t      a;
        word_t      b;
        word_t      res;
        instrInfo_t op;
        commit_t    entry;
        for (int r = 0; r < 32; r++) begin
            regs[5'(r)] = '0;
        end
        curPc = resetPc;
        for (int step = 0; step < 4 * progLen && curPc != haltPc; step++) begin
            op     = info[7'((curPc - resetPc) >> 2)];
            a      = regs[op.rs1];
            b      = regs[op.rs2];
            nextPc = curPc + 32'd4;
            res    = '0;
            case (op.kind)
                kAdd:   res = a + b;
                kSub:   res = a - b;
                kAnd:   res = a & b;
                kOr:    res = a | b;
                kXor:   res = a ^ b;
                kSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                kAddi:  res = a + op.imm;
                kLui:   res = op.imm;
                kAuipc: res = curPc + op.imm;
                kBeq:   nextPc = (a == b) ? curPc + op.imm : nextPc;
                kBne:   nextPc = (a != b) ? curPc + op.imm : nextPc;
                kJal: begin
                    res    = curPc + 32'd4;  // Link address
                    nextPc = curPc + op.imm;
                end
                default: ;
            endcase
            // Only writes to x1..x31 commit
            if (op.kind != kBeq && op.kind != kBne && op.rd != '0) begin
                regs[op.rd] = res;
                entry.pc    = curPc;
                entry.rd    = op.rd;
                entry.data  = res;
                expQ.push_back(entry);
            end
            curPc = nextPc;
        end
    endfunction

    task automatic reportMismatch(string sig, word_t got, word_t want);
        $display("Fail at %0t ns: %s = %h, expected %h", $time, sig, got, want);
        $display("TEST FAILED");
        $fatal(1, "Writeback mismatch");
    endtask

    // ==================================================
    // Commit checker
    // ==================================================
    always @(negedge CLK) begin : compare
        commit_t want;
        if (rstN && wbValid) begin
            assert (expQ.size() > 0) else begin
                $display("Unexpected commit of x%0d from pc %h", wbRd, wbPc);
                $display("TEST FAILED");
                $fatal(1, "Commit beyond the expected sequence");
            end
            want = expQ.pop_front();
            assert (wbPc == want.pc) else reportMismatch("wbPc", wbPc, want.pc);
            assert (wbRd == want.rd) else reportMismatch("wbRd", word_t'(wbRd), word_t'(want.rd));
            assert (wbData == want.data) else reportMismatch("wbData", wbData, want.data);
            seenCount++;
        end
    end

    initial begin
        int cycles;
        void'($urandom(83));
        buildProgram();
        refRun();

        cycles = 0;
        while (!rstN && cycles < 100) begin
            @(negedge CLK);
            cycles++;
        end
        if (!rstN) begin
            $display("Reset was never released");
            $display("TEST FAILED");
            $fatal(1, "Reset timeout");
        end

        cycles = 0;
        while (!(pc == haltPc && expQ.size() == 0) && cycles < runLimit) begin
            @(negedge CLK);
            cycles++;
        end
        if (!(pc == haltPc && expQ.size() == 0)) begin
            $display("Timed out after %0d cycles before the core reached the halt address",
                     runLimit);
            $display("TEST FAILED");
            $fatal(1, "Run timeout");
        end

        // Pipeline drain to catch stray commits behind the halt loop
        for (int d = 0; d < 4; d++) begin
            @(negedge CLK);
        end
        $display("Checked %0d register writes", seenCount);
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- dv/rvCore_chk.sv
// Core invariant checks
// Bound into rvCore, watches the writeback port and the fetch address

`timescale 1ns/100ps

module rvCoreChk (
    input logic              CLK,
    input logic              rstN,
    input rvIsaPkg::word_t   pc,
    input logic              wbValid,
    input rvIsaPkg::regIdx_t wbRd
);

    // Writes to x0 never reach the port
    noX0Commit: assert property (@(posedge CLK) disable iff (!rstN)
        wbValid |-> wbRd != '0)
        else $error("wbValid raised with wbRd equal to zero");

    // First cycle out of reset
    resetClearsWb: assert property (@(posedge CLK) $rose(rstN) |-> !wbValid)
        else $error("wbValid high in the first cycle after reset");

    pcAligned: assert property (@(posedge CLK) disable iff (!rstN)
        pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

endmodule

bind rvCore rvCoreChk chk (
    .CLK     (CLK),
    .rstN    (rstN),
    .pc      (pc),
    .wbValid (wbValid),
    .wbRd    (wbRd)
);

//--- run.sh
#!/bin/sh
# Build and run the rvCore testbench with Verilator.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rvCoreTb -f rvCore.f -o rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/rvCoreSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0

//--- rvCore.f
source/rvIsaPkg.sv
source/corePkg.sv
source/fetchStage.sv
source/decoder.sv
source/regFile.sv
source/executeStage.sv
source/rvCore.sv
dv/clockGen.sv
dv/rvCore_chk.sv
dv/rvCoreTb.sv

//--- source/corePkg.sv
// Core microarchitecture types
// ALU operation codes, decoded control bundle and the stage-to-stage packets

package corePkg;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB
    } aluOp_e;

    // Operand A source
    typedef enum logic [1:0] {
        srcAReg,
        srcAZero,
        srcAPc
    } srcASel_e;

    typedef struct packed {
        logic     regWrite;
        aluOp_e   aluOp;
        srcASel_e srcASel;
        logic     useImm;    // Operand B from immediate
        logic     isBranch;
        logic     branchNe;  // Taken on not-equal
        logic     isJump;
    } ctrl_t;

    // Fetch register contents
    typedef struct packed {
        logic            valid;
        rvIsaPkg::word_t pc;
        rvIsaPkg::word_t instr;
    } fetchPkt_t;

    // Writeback register contents
    typedef struct packed {
        logic              valid;
        rvIsaPkg::regIdx_t rd;
        rvIsaPkg::word_t   data;
        rvIsaPkg::word_t   pc;
    } wbPkt_t;

endpackage

//--- source/decoder.sv
// Instruction decoder
// Breaks the word into fields, maps opcode/funct3/funct7 to the control
// bundle and sign-extends the immediate for the instruction's format

`timescale 1ns/100ps

module decoder (
    input  rvIsaPkg::word_t        instr,
    output corePkg::ctrl_t         ctrl,
    output rvIsaPkg::word_t        imm,
    output rvIsaPkg::instrFields_t fields
);
    import rvIsaPkg::*;
    import corePkg::*;

    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Sub  = 7'b0100000;

    word_t immI;
    word_t immU;
    word_t immB;
    word_t immJ;
    logic  f7Legal;

    assign fields = instrFields_t'(instr);

    // Immediate formats
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immU = {instr[31:12], 12'b0};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Only SUB may use a non-zero funct7
    assign f7Legal = (fields.funct7 == f7Base) ||
                     (fields.funct7 == f7Sub && fields.funct3 == f3AddSub);

    always_comb begin
        ctrl         = '0;       // No-op unless recognised
        ctrl.aluOp   = aluAdd;
        ctrl.srcASel = srcAReg;
        imm          = immI;
        case (opcode_e'(fields.opcode))
            opReg: begin
                ctrl.regWrite = f7Legal;
                case (fields.funct3)
                    f3AddSub: ctrl.aluOp = fields.funct7[5] ? aluSub : aluAdd;
                    f3Slt:    ctrl.aluOp = aluSlt;
                    f3Xor:    ctrl.aluOp = aluXor;
                    f3Or:     ctrl.aluOp = aluOr;
                    f3And:    ctrl.aluOp = aluAnd;
                    default:  ctrl.regWrite = 1'b0;  // Shifts, SLTU
                endcase
            end
            opImm: begin
                ctrl.regWrite = (fields.funct3 == f3AddSub);  // ADDI only
                ctrl.useImm   = 1'b1;
            end
            opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcASel  = srcAZero;
                ctrl.aluOp    = aluPassB;
                ctrl.useImm   = 1'b1;
                imm           = immU;
            end
            opAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcASel  = srcAPc;
                ctrl.useImm   = 1'b1;
                imm           = immU;
            end
            opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcASel  = srcAPc;  // Link value PC+4 through the ALU
                ctrl.isJump   = 1'b1;
                imm           = immJ;
            end
            opBranch: begin
                ctrl.aluOp    = aluSub;  // Equality from a zero difference
                ctrl.isBranch = (fields.funct3 == f3Beq) || (fields.funct3 == f3Bne);
                ctrl.branchNe = (fields.funct3 == f3Bne);
                imm           = immB;
            end
            default: ;
        endcase
    end

endmodule

//--- source/executeStage.sv
// Execute stage
// Decodes the fetched instruction, forwards the writeback result, runs the
// ALU, resolves jumps and branches, and registers the writeback packet

`timescale 1ns/100ps

module executeStage (
    input  logic               CLK,
    input  logic               rstN,
    input  corePkg::fetchPkt_t fetchPkt,
    input  rvIsaPkg::word_t    rd1,
    input  rvIsaPkg::word_t    rd2,
    output rvIsaPkg::regIdx_t  rs1,
    output rvIsaPkg::regIdx_t  rs2,
    output logic               redirect,
    output rvIsaPkg::word_t    redirectPc,
    output corePkg::wbPkt_t    wbPkt
);
    import rvIsaPkg::*;
    import corePkg::*;

    ctrl_t        ctrl;
    word_t        imm;
    instrFields_t fields;
    word_t        fwdA;
    word_t        fwdB;
    word_t        opA;
    word_t        opB;
    word_t        aluRes;
    logic         isZero;

    decoder decode (
        .instr  (fetchPkt.instr),
        .ctrl   (ctrl),
        .imm    (imm),
        .fields (fields)
    );

    assign rs1 = fields.rs1;
    assign rs2 = fields.rs2;

    // ==================================================
    // Forwarding and operand select
    // ==================================================
    // wbPkt.valid already excludes x0
    assign fwdA = (wbPkt.valid && wbPkt.rd == fields.rs1) ? wbPkt.data : rd1;
    assign fwdB = (wbPkt.valid && wbPkt.rd == fields.rs2) ? wbPkt.data : rd2;

    always_comb begin
        case (ctrl.srcASel)
            srcAZero: opA = '0;
            srcAPc:   opA = fetchPkt.pc;
            default:  opA = fwdA;
        endcase
    end

    assign opB = ctrl.isJump ? word_t'(4) : (ctrl.useImm ? imm : fwdB);  // Return address

    // ==================================================
    // ALU
    // ==================================================
    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   aluRes = opA + opB;
            aluSub:   aluRes = opA - opB;
            aluAnd:   aluRes = opA & opB;
            aluOr:    aluRes = opA | opB;
            aluXor:   aluRes = opA ^ opB;
            aluSlt:   aluRes = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluPassB: aluRes = opB;
            default:  aluRes = '0;
        endcase
    end

    // Branch resolution
    assign isZero     = (aluRes == '0);
    assign redirect   = fetchPkt.valid &&
                        (ctrl.isJump || (ctrl.isBranch && (isZero ^ ctrl.branchNe)));
    assign redirectPc = fetchPkt.pc + imm;

    // ==================================================
    // Writeback register
    // ==================================================
    always_ff @(posedge CLK) begin
        wbPkt.rd   <= fields.rd;
        wbPkt.data <= aluRes;
        wbPkt.pc   <= fetchPkt.pc;
        if (!rstN) begin
            wbPkt.valid <= 1'b0;
        end else begin
            wbPkt.valid <= fetchPkt.valid && ctrl.regWrite && (fields.rd != '0);
        end
    end

endmodule

//--- source/fetchStage.sv
// Fetch stage
// Holds the PC, picks the next fetch address and registers the fetched
// instruction for execute. A redirect squashes the wrong-path fetch

`timescale 1ns/100ps

module fetchStage #(
    parameter rvIsaPkg::word_t resetPc = 32'h00400000
) (
    input  logic                CLK,
    input  logic                rstN,
    input  rvIsaPkg::word_t     instr,
    input  logic                redirect,
    input  rvIsaPkg::word_t     redirectPc,
    output rvIsaPkg::word_t     pc,
    output corePkg::fetchPkt_t  fetchPkt
);
    import rvIsaPkg::*;

    word_t nextPc;

    // ==================================================
    // Next PC
    // ==================================================
    // Static not-taken prediction, execute overrides
    assign nextPc = redirect ? redirectPc : pc + word_t'(4);

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // ==================================================
    // Fetch register
    // ==================================================
    always_ff @(posedge CLK) begin
        fetchPkt.pc    <= pc;
        fetchPkt.instr <= instr;
        if (!rstN) begin
            fetchPkt.valid <= 1'b0;
        end else begin
            fetchPkt.valid <= !redirect;  // Drop the slot behind a taken branch
        end
    end

endmodule

//--- source/regFile.sv
// Integer register file
// 32 x 32-bit, two combinational reads and one write on the clock edge.
// x0 always reads as zero

`timescale 1ns/100ps

module regFile (
    input  logic               CLK,
    input  rvIsaPkg::regIdx_t  rs1,
    input  rvIsaPkg::regIdx_t  rs2,
    output rvIsaPkg::word_t    rd1,
    output rvIsaPkg::word_t    rd2,
    input  corePkg::wbPkt_t    wbPkt
);
    import rvIsaPkg::*;

    word_t regs [32];

    always_ff @(posedge CLK) begin
        if (wbPkt.valid) begin
            regs[wbPkt.rd] <= wbPkt.data;
        end
    end

    // Same-cycle write is not bypassed here
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/rvCore.sv
// RV32I core top level
// Three-stage in-order pipeline of fetch, execute and writeback, with the
// register file written from the writeback packet

`timescale 1ns/100ps

module rvCore #(
    parameter rvIsaPkg::word_t resetPc = 32'h00400000
) (
    input  logic               CLK,
    input  logic               rstN,
    input  rvIsaPkg::word_t    instr,
    output rvIsaPkg::word_t    pc,
    output logic               wbValid,
    output rvIsaPkg::regIdx_t  wbRd,
    output rvIsaPkg::word_t    wbData,
    output rvIsaPkg::word_t    wbPc
);
    import rvIsaPkg::*;
    import corePkg::*;

    fetchPkt_t fetchPkt;
    wbPkt_t    wbPkt;
    logic      redirect;
    word_t     redirectPc;
    regIdx_t   rs1;
    regIdx_t   rs2;
    word_t     rd1;
    word_t     rd2;

    // ==================================================
    // Stages
    // ==================================================
    fetchStage #(
        .resetPc (resetPc)
    ) fetch (
        .CLK        (CLK),
        .rstN       (rstN),
        .instr      (instr),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .pc         (pc),
        .fetchPkt   (fetchPkt)
    );

    executeStage execute (
        .CLK        (CLK),
        .rstN       (rstN),
        .fetchPkt   (fetchPkt),
        .rd1        (rd1),
        .rd2        (rd2),
        .rs1        (rs1),
        .rs2        (rs2),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .wbPkt      (wbPkt)
    );

    regFile regs (
        .CLK   (CLK),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd1   (rd1),
        .rd2   (rd2),
        .wbPkt (wbPkt)
    );

    // Commit report
    assign wbValid = wbPkt.valid;
    assign wbRd    = wbPkt.rd;
    assign wbData  = wbPkt.data;
    assign wbPc    = wbPkt.pc;

endmodule

//--- source/rvIsaPkg.sv
// RV32I ISA definitions
// Widths, base opcodes, funct3 codes and the raw instruction field layout
// shared by the decoder and the datapath

package rvIsaPkg;

    // ==================================================
    // Widths
    // ==================================================
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      regIdx_t;

    // ==================================================
    // Opcodes
    // ==================================================
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,  // R-type ALU
        opImm    = 7'b0010011,  // I-type ALU
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opBranch = 7'b1100011
    } opcode_e;

    // funct3 codes for ALU ops
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct3 codes for branches
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    // Instruction word in its native bit order, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        regIdx_t    rs2;
        regIdx_t    rs1;
        logic [2:0] funct3;
        regIdx_t    rd;
        logic [6:0] opcode;
    } instrFields_t;

endpackage
